/* design/tlk_tx_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Link constants and types for the serial link transmit path.
// Frame sizes are shortened for simulation; data mode only, no test modes.
////////////////////////////////////////////////////////////////////////////

package tlk_tx_pkg;

    // Link and frame sizes
    localparam int WORD_W      = 16;
    localparam int BODY_WORDS  = 8;
    localparam int BODY_BYTES  = 2 * BODY_WORDS;
    localparam int SYNC_CYCLES = 6;
    localparam int GAP_CYCLES  = 4;
    localparam int FIFO_DEPTH  = 16;
    localparam int COUNT_W     = $clog2(FIFO_DEPTH + 1);
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    // Wide enough for the longest of sync, body and gap
    localparam int PHASE_W     = 4;

    // Comma pair
    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] D5_6  = 8'hC5;
    // Start of frame
    localparam logic [7:0] K27_7 = 8'hFB;
    localparam logic [7:0] K28_2 = 8'h5C;
    // End of frame
    localparam logic [7:0] K30_7 = 8'hFE;
    localparam logic [7:0] K29_7 = 8'hFD;

    localparam logic [WORD_W-1:0] HEAD_0 = 16'hEB90;
    localparam logic [WORD_W-1:0] HEAD_1 = 16'hE116;

    // File-sign word bytes
    localparam logic [7:0] TX_IND   = 8'h81;
    localparam logic [7:0] FILE_END = 8'h01;

    // What a beat carries to the encoder
    typedef enum logic [3:0] {
        FLD_IDLE,
        FLD_COMMA,
        FLD_SOF,
        FLD_HEAD0,
        FLD_HEAD1,
        FLD_FILE_SIGN,
        FLD_FRAME_NUM,
        FLD_VLD_LEN,
        FLD_DATA,
        FLD_VERIFY,
        FLD_EOF
    } link_field_e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SYNC,
        ST_SOF,
        ST_HEAD,
        ST_FILE_SIGN,
        ST_FRAME_NUM,
        ST_VLD_LEN,
        ST_DATA,
        ST_VERIFY,
        ST_EOF,
        ST_GAP
    } tx_state_e;

    typedef struct packed {
        link_field_e       field;
        logic [WORD_W-1:0] word;
        logic              last;
    } link_beat_t;

    typedef struct packed {
        logic              tkmsb;
        logic              tklsb;
        logic [WORD_W-1:0] txd;
    } tx_symbol_t;

endpackage

/* design/tlk_tx_word_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Word FIFO with first-word fall-through head output.
// Pop must only be raised when the count is non-zero; it is not checked.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlk_tx_word_fifo
    import tlk_tx_pkg::*;
(
    input  logic               clk,
    input  logic               i_soft_reset,
    input  logic               i_data_valid,
    input  logic [WORD_W-1:0]  i_data_word,
    output logic               o_data_ready,
    input  logic               i_pop,
    output logic [WORD_W-1:0]  o_head_word,
    output logic [COUNT_W-1:0] o_count
);

    logic [WORD_W-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  push;

    assign o_data_ready = (o_count != COUNT_W'(FIFO_DEPTH));
    assign push         = i_data_valid & o_data_ready;
    assign o_head_word  = mem[rd_ptr];

    // Storage array
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= i_data_word;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !i_pop)
            begin
                o_count <= o_count + 1'b1;
            end
            else if (!push && i_pop)
            begin
                o_count <= o_count - 1'b1;
            end
        end
    end

endmodule

/* design/tlk_tx_frame_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Frame FSM; a run starts only with a full body in the FIFO.
// Later frames do not wait, so the source must keep up with the link.
// i_body_num and i_tail_bytes must stay stable for the whole run.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlk_tx_frame_sequencer
    import tlk_tx_pkg::*;
(
    input  logic               clk,
    input  logic               i_soft_reset,
    input  logic               i_tx_start,
    input  logic [15:0]        i_body_num,
    input  logic [15:0]        i_tail_bytes,
    input  logic [COUNT_W-1:0] i_fifo_count,
    input  logic [WORD_W-1:0]  i_fifo_word,
    output logic               o_pop,
    output link_beat_t         o_beat,
    output logic               o_tx_interrupt
);

    tx_state_e          state;
    logic [PHASE_W-1:0] phase;
    logic [15:0]        frame_num;
    logic [WORD_W-1:0]  verify_cnt;
    logic               last_frame;
    logic               finish_pend;
    link_beat_t         beat_next;

    assign last_frame = (frame_num == i_body_num);
    assign o_pop      = (state == ST_DATA);

    ////////////////////////////////////////////////////////////////////////////
    // State walk
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            state          <= ST_IDLE;
            phase          <= '0;
            frame_num      <= '0;
            verify_cnt     <= '0;
            finish_pend    <= 1'b0;
            o_tx_interrupt <= 1'b0;
        end
        else
        begin
            finish_pend    <= 1'b0;
            // Extra stage keeps the pulse in line with the beat stream
            o_tx_interrupt <= finish_pend;
            phase          <= phase + 1'b1;
            case (state)
                ST_IDLE:
                begin
                    phase     <= '0;
                    frame_num <= '0;
                    if (i_tx_start && (i_fifo_count >= COUNT_W'(BODY_WORDS)))
                    begin
                        state <= ST_SYNC;
                    end
                end
                ST_SYNC:
                begin
                    if (phase == PHASE_W'(SYNC_CYCLES - 1))
                    begin
                        state <= ST_SOF;
                    end
                end
                ST_SOF:
                begin
                    phase      <= '0;
                    verify_cnt <= '0;
                    state      <= ST_HEAD;
                end
                ST_HEAD:
                begin
                    if (phase[0])
                    begin
                        state <= ST_FILE_SIGN;
                    end
                end
                ST_FILE_SIGN,
                ST_FRAME_NUM,
                ST_VLD_LEN:
                begin
                    phase      <= '0;
                    verify_cnt <= verify_cnt + 2'd2;
                    state      <= tx_state_e'(state + 1'b1);
                end
                ST_DATA:
                begin
                    verify_cnt <= verify_cnt + 2'd2;
                    if (phase == PHASE_W'(BODY_WORDS - 1))
                    begin
                        state <= ST_VERIFY;
                    end
                end
                ST_VERIFY:
                begin
                    state <= ST_EOF;
                end
                ST_EOF:
                begin
                    phase <= '0;
                    state <= ST_GAP;
                end
                ST_GAP:
                begin
                    if (phase == PHASE_W'(GAP_CYCLES - 1))
                    begin
                        if (last_frame)
                        begin
                            finish_pend <= 1'b1;
                            state       <= ST_IDLE;
                        end
                        else
                        begin
                            frame_num <= frame_num + 1'b1;
                            state     <= ST_SOF;
                        end
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Beat content for the current state
    always_comb
    begin
        beat_next.field = FLD_IDLE;
        beat_next.word  = '0;
        beat_next.last  = last_frame;
        case (state)
            ST_SYNC,
            ST_GAP:       beat_next.field = FLD_COMMA;
            ST_SOF:       beat_next.field = FLD_SOF;
            ST_HEAD:      beat_next.field = phase[0] ? FLD_HEAD1 : FLD_HEAD0;
            ST_FILE_SIGN: beat_next.field = FLD_FILE_SIGN;
            ST_FRAME_NUM:
            begin
                beat_next.field = FLD_FRAME_NUM;
                beat_next.word  = frame_num;
            end
            ST_VLD_LEN:
            begin
                beat_next.field = FLD_VLD_LEN;
                beat_next.word  = last_frame ? i_tail_bytes : WORD_W'(BODY_BYTES);
            end
            ST_DATA:
            begin
                beat_next.field = FLD_DATA;
                beat_next.word  = i_fifo_word;
            end
            ST_VERIFY:
            begin
                beat_next.field = FLD_VERIFY;
                beat_next.word  = verify_cnt;
            end
            ST_EOF:       beat_next.field = FLD_EOF;
            default:      beat_next.field = FLD_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            o_beat <= '0;
        end
        else
        begin
            o_beat <= beat_next;
        end
    end

endmodule

/* design/tlk_tx_symbol_encoder.sv */
////////////////////////////////////////////////////////////////////////////
// Maps beats to link words and K-flags, one register stage.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlk_tx_symbol_encoder
    import tlk_tx_pkg::*;
(
    input  logic       clk,
    input  logic       i_soft_reset,
    input  link_beat_t i_beat,
    output tx_symbol_t o_symbol
);

    tx_symbol_t sym_next;

    always_comb
    begin
        sym_next.tkmsb = 1'b0;
        sym_next.tklsb = 1'b0;
        sym_next.txd   = '0;
        case (i_beat.field)
            FLD_COMMA:
            begin
                // K-code only in the low byte
                sym_next.tklsb = 1'b1;
                sym_next.txd   = {D5_6, K28_5};
            end
            FLD_SOF:
            begin
                sym_next.tkmsb = 1'b1;
                sym_next.tklsb = 1'b1;
                sym_next.txd   = {K28_2, K27_7};
            end
            FLD_EOF:
            begin
                sym_next.tkmsb = 1'b1;
                sym_next.tklsb = 1'b1;
                sym_next.txd   = {K29_7, K30_7};
            end
            FLD_HEAD0:     sym_next.txd = HEAD_0;
            FLD_HEAD1:     sym_next.txd = HEAD_1;
            FLD_FILE_SIGN: sym_next.txd = {TX_IND, i_beat.last ? FILE_END : 8'h00};
            FLD_FRAME_NUM,
            FLD_VLD_LEN,
            FLD_DATA,
            FLD_VERIFY:    sym_next.txd = i_beat.word;
            default:       sym_next.txd = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            o_symbol <= '0;
        end
        else
        begin
            o_symbol <= sym_next;
        end
    end

endmodule

/* design/tlk_tx_top.sv */
////////////////////////////////////////////////////////////////////////////
// Transmit path top: FIFO, frame FSM and symbol encoder in a pipeline.
// Normal data mode only; transceiver control pins are tied off outside.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlk_tx_top
    import tlk_tx_pkg::*;
(
    input  logic              clk,
    input  logic              i_soft_reset,
    input  logic              i_tx_start,
    input  logic [15:0]       i_body_num,
    input  logic [15:0]       i_tail_bytes,
    input  logic              i_data_valid,
    input  logic [WORD_W-1:0] i_data_word,
    output logic              o_data_ready,
    output tx_symbol_t        o_symbol,
    output logic              o_tx_interrupt
);

    logic [WORD_W-1:0]  head_word;
    logic [COUNT_W-1:0] fifo_count;
    logic               pop;
    link_beat_t         beat;
    logic               seq_interrupt;

    tlk_tx_word_fifo u_fifo (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_data_valid (i_data_valid),
        .i_data_word  (i_data_word),
        .o_data_ready (o_data_ready),
        .i_pop        (pop),
        .o_head_word  (head_word),
        .o_count      (fifo_count)
    );

    tlk_tx_frame_sequencer u_sequencer (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_tx_start     (i_tx_start),
        .i_body_num     (i_body_num),
        .i_tail_bytes   (i_tail_bytes),
        .i_fifo_count   (fifo_count),
        .i_fifo_word    (head_word),
        .o_pop          (pop),
        .o_beat         (beat),
        .o_tx_interrupt (seq_interrupt)
    );

    tlk_tx_symbol_encoder u_encoder (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_beat       (beat),
        .o_symbol     (o_symbol)
    );

    // Match the encoder stage
    always_ff @(posedge clk)
    begin
        if (i_soft_reset)
        begin
            o_tx_interrupt <= 1'b0;
        end
        else
        begin
            o_tx_interrupt <= seq_interrupt;
        end
    end

endmodule

/* verification/tlk_tx_tb_checks.svh */
////////////////////////////////////////////////////////////////////////////
// Compare tasks for the transmit path testbench, included in its module.
// The including module must define stop_with_failure before the include.
////////////////////////////////////////////////////////////////////////////

`ifndef TLK_TX_TB_CHECKS_SVH
`define TLK_TX_TB_CHECKS_SVH

// Link symbol, K-flags and data word together
task automatic check_symbol(input tx_symbol_t got, input tx_symbol_t exp, input string what);
    if (got !== exp)
    begin
        stop_with_failure($sformatf("ERR %0d ns: %s: got k=%b%b txd=%h, expected k=%b%b txd=%h",
            $time, what, got.tkmsb, got.tklsb, got.txd, exp.tkmsb, exp.tklsb, exp.txd));
    end
endtask

// Interrupt pulse level
task automatic check_interrupt(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
        stop_with_failure($sformatf("ERR %0d ns: %s: o_tx_interrupt is %b, expected %b",
            $time, what, got, exp));
    end
endtask

// Input stream back-pressure
task automatic check_ready(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
        stop_with_failure($sformatf("ERR %0d ns: %s: o_data_ready is %b, expected %b",
            $time, what, got, exp));
    end
endtask

`endif

/* verification/tlk_tx_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the transmit path; runs come from the stimulus file.
// Inputs change on the falling edge, outputs are sampled there as well.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlk_tx_tb
    import tlk_tx_pkg::*;
();

    localparam int STIM_DEPTH  = 256;
    localparam int WAIT_LIMIT  = 200;
    localparam int IDLE_CYCLES = 6;
    // Run symbol index, counted from the first sync comma, where reset cuts frame 0
    localparam int ABORT_AT    = SYNC_CYCLES + 5;

    logic              clk;
    logic              i_soft_reset;
    logic              i_tx_start;
    logic [15:0]       i_body_num;
    logic [15:0]       i_tail_bytes;
    logic              i_data_valid;
    logic [WORD_W-1:0] i_data_word;
    logic              o_data_ready;
    tx_symbol_t        o_symbol;
    logic              o_tx_interrupt;

    logic [15:0] stim_mem [STIM_DEPTH];
    tx_symbol_t  exp_q [$];
    int          accepted;
    int          run_num;
    bit          abort_req;

    tlk_tx_top dut (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_tx_start     (i_tx_start),
        .i_body_num     (i_body_num),
        .i_tail_bytes   (i_tail_bytes),
        .i_data_valid   (i_data_valid),
        .i_data_word    (i_data_word),
        .o_data_ready   (o_data_ready),
        .o_symbol       (o_symbol),
        .o_tx_interrupt (o_tx_interrupt)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    `include "tlk_tx_tb_checks.svh"

    function automatic tx_symbol_t make_symbol(input logic km, input logic kl,
                                               input logic [WORD_W-1:0] d);
        tx_symbol_t s;
        s.tkmsb = km;
        s.tklsb = kl;
        s.txd   = d;
        return s;
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        i_soft_reset = 1'b1;
        i_tx_start   = 1'b0;
        i_data_valid = 1'b0;
        repeat (2) @(negedge clk);
        i_soft_reset = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Frame model of the sync burst and body+1 frames with their gaps
    ////////////////////////////////////////////////////////////////////////////
    task automatic build_expected(input logic [15:0] body, input logic [15:0] tail,
                                  input int base);
        int   f;
        int   i;
        logic last;
        exp_q.delete();
        repeat (SYNC_CYCLES) exp_q.push_back(make_symbol(1'b0, 1'b1, {D5_6, K28_5}));
        for (f = 0; f <= int'(body); f++)
        begin
            last = (f == int'(body));
            exp_q.push_back(make_symbol(1'b1, 1'b1, {K28_2, K27_7}));
            exp_q.push_back(make_symbol(1'b0, 1'b0, HEAD_0));
            exp_q.push_back(make_symbol(1'b0, 1'b0, HEAD_1));
            exp_q.push_back(make_symbol(1'b0, 1'b0, {TX_IND, last ? FILE_END : 8'h00}));
            exp_q.push_back(make_symbol(1'b0, 1'b0, 16'(f)));
            exp_q.push_back(make_symbol(1'b0, 1'b0, last ? tail : 16'(BODY_BYTES)));
            for (i = 0; i < BODY_WORDS; i++)
            begin
                exp_q.push_back(make_symbol(1'b0, 1'b0, stim_mem[base + f * BODY_WORDS + i]));
            end
            // Two per file-sign, number, length and data word
            exp_q.push_back(make_symbol(1'b0, 1'b0, 16'(2 * (3 + BODY_WORDS))));
            exp_q.push_back(make_symbol(1'b1, 1'b1, {K29_7, K30_7}));
            repeat (GAP_CYCLES) exp_q.push_back(make_symbol(1'b0, 1'b1, {D5_6, K28_5}));
        end
    endtask

    // Offers the run's words with random idle gaps until all are taken
    task automatic feed_words(input int base, input int n_words);
        int idx;
        int gap;
        int stall;
        idx = 0;
        while (idx < n_words && !abort_req)
        begin
            gap = int'($urandom_range(1, 0));
            i_data_valid = 1'b0;
            repeat (gap) @(negedge clk);
            i_data_valid = 1'b1;
            i_data_word  = stim_mem[base + idx];
            stall = 0;
            while (!o_data_ready && !abort_req)
            begin
                stall++;
                if (stall > WAIT_LIMIT)
                    stop_with_failure("Input stream stalled: o_data_ready stayed low too long");
                @(negedge clk);
            end
            @(negedge clk);
            idx++;
            accepted++;
        end
        i_data_valid = 1'b0;
    endtask

    task automatic abort_mid_frame();
        int waited;
        abort_req    = 1'b1;
        i_soft_reset = 1'b1;
        waited = 0;
        @(negedge clk);
        while (o_symbol != '0)
        begin
            waited++;
            if (waited >= 2)
                stop_with_failure("Symbol did not return to idle within two cycles of reset");
            @(negedge clk);
        end
        @(negedge clk);
        i_soft_reset = 1'b0;
        // FSM back in idle, so nothing resumes after release
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk);
            check_symbol(o_symbol, '0, "idle symbol after a mid-frame reset");
        end
    endtask

    task automatic watch_link(input int n_words, input logic do_abort);
        int    prefill;
        int    waited;
        int    i;
        string what;
        prefill = (n_words < FIFO_DEPTH) ? n_words : FIFO_DEPTH;
        waited = 0;
        while (accepted < prefill)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
                stop_with_failure("Timed out while filling the FIFO before start");
            @(negedge clk);
        end
        if (n_words > FIFO_DEPTH)
            check_ready(o_data_ready, 1'b0, "ready with a full FIFO and words pending");
        i_tx_start = 1'b1;
        @(negedge clk);
        i_tx_start = 1'b0;
        waited = 0;
        while (o_symbol == '0)
        begin
            check_interrupt(o_tx_interrupt, 1'b0, "interrupt before the sync burst");
            waited++;
            if (waited > WAIT_LIMIT)
                stop_with_failure("Timed out waiting for the sync burst after start");
            @(negedge clk);
        end
        i = 0;
        while (i < exp_q.size() && !abort_req)
        begin
            what = $sformatf("run %0d symbol %0d", run_num, i);
            check_symbol(o_symbol, exp_q[i], what);
            check_interrupt(o_tx_interrupt, 1'b0, what);
            if (do_abort && i == ABORT_AT)
                abort_mid_frame();
            else
            begin
                i++;
                @(negedge clk);
            end
        end
        if (!abort_req)
        begin
            check_symbol(o_symbol, '0, "idle symbol after the last gap");
            check_interrupt(o_tx_interrupt, 1'b1, "interrupt after the last gap");
            repeat (IDLE_CYCLES)
            begin
                @(negedge clk);
                check_symbol(o_symbol, '0, "idle symbol after the interrupt");
                check_interrupt(o_tx_interrupt, 1'b0, "interrupt after its pulse");
            end
        end
    endtask

    initial
    begin
        int          n_runs;
        int          run;
        int          rd_idx;
        int          base;
        int          n_words;
        logic [15:0] body;
        logic [15:0] tail;
        logic        do_abort;
        i_soft_reset = 1'b1;
        i_tx_start   = 1'b0;
        i_body_num   = '0;
        i_tail_bytes = '0;
        i_data_valid = 1'b0;
        i_data_word  = '0;
        accepted     = 0;
        run_num      = 0;
        abort_req    = 1'b0;
        void'($urandom(32'hf18b6eac));
        $readmemh("verification/tlk_tx_stimulus.txt", stim_mem);
        n_runs = int'(stim_mem[0]);
        if (n_runs == 0)
            stop_with_failure("Stimulus file holds no test runs");
        rd_idx = 1;
        for (run = 1; run <= n_runs; run++)
        begin
            body     = stim_mem[rd_idx];
            tail     = stim_mem[rd_idx + 1];
            do_abort = stim_mem[rd_idx + 2][0];
            base     = rd_idx + 3;
            n_words  = (int'(body) + 1) * BODY_WORDS;
            rd_idx   = base + n_words;
            if (rd_idx > STIM_DEPTH)
                stop_with_failure("Stimulus run extends past the end of the file buffer");
            run_num      = run;
            i_body_num   = body;
            i_tail_bytes = tail;
            apply_reset();
            check_symbol(o_symbol, '0, "symbol after reset");
            check_interrupt(o_tx_interrupt, 1'b0, "interrupt after reset");
            check_ready(o_data_ready, 1'b1, "ready after reset");
            build_expected(body, tail, base);
            accepted  = 0;
            abort_req = 1'b0;
            fork
                feed_words(base, n_words);
                watch_link(n_words, do_abort);
            join
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verification/tlk_tx_stimulus.txt */
// Columns: first the run count; then per run body count, tail bytes, abort flag,
// followed by (body count + 1) x 8 data words; all values 16-bit hex
0004
// Run 1: one frame
0000 000B 0000
1111 2222 3333 4444 5555 6666 7777 8888
// Run 2: three frames, 24 words overfill the 16-word FIFO before start
0002 0006 0000
C001 C002 C003 C004 C005 C006 C007 C008
C109 C10A C10B C10C C10D C10E C10F C110
C211 C212 C213 C214 C215 C216 C217 C218
// Run 3: soft reset in the middle of frame 0
0001 0010 0001
D0D0 D1D1 D2D2 D3D3 D4D4 D5D5 D6D6 D7D7
D8D8 D9D9 DADA DBDB DCDC DDDD DEDE DFDF
// Run 4: two frames after the aborted run
0001 0003 0000
0F01 1E02 2D03 3C04 4B05 5A06 6907 7808
8709 960A A50B B40C C30D D20E E10F F000

/* tlk_tx.f */
+incdir+verification
design/tlk_tx_pkg.sv
design/tlk_tx_word_fifo.sv
design/tlk_tx_frame_sequencer.sv
design/tlk_tx_symbol_encoder.sv
design/tlk_tx_top.sv
verification/tlk_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the transmit path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tlk_tx_tb -f tlk_tx.f -o tlk_tx_sim
sim_out=$(./obj_dir/tlk_tx_sim || true)
printf '%s\n' "$sim_out"
if printf '%s\n' "$sim_out" | grep -q '^RESULT: PASS$'
then
    exit 0
fi
exit 1
